//--- list.f
+incdir+src
src/rv_pkg.sv
src/inst_queue.sv
src/id_unit.sv
src/regfile.sv
src/csr_file.sv
src/ex_unit.sv
src/id_core.sv
tests/tb_id_core.sv

//--- run.sh
#!/bin/sh
# build the id_core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_id_core \
  --Mdir obj_dir -o sim_tb_id_core
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_tb_id_core
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

//--- src/csr_file.sv
/* machine CSR file
   mstatus, mtvec, mscratch and mepc with write, set and clear */
`timescale 1ns/1ps
`include "rv_defs.svh"

module csr_file (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_en,
  input  logic [11:0]     i_addr,
  input  rv_pkg::csr_op_e i_op,
  input  rv_pkg::xlen_t   i_wdata,
  output rv_pkg::xlen_t   o_rdata
);

  rv_pkg::xlen_t mstatus;
  rv_pkg::xlen_t mtvec;
  rv_pkg::xlen_t mscratch;
  rv_pkg::xlen_t mepc;
  rv_pkg::xlen_t wval;

  always_comb begin
    case (i_addr)
      `CSR_MSTATUS:  o_rdata = mstatus;
      `CSR_MTVEC:    o_rdata = mtvec;
      `CSR_MSCRATCH: o_rdata = mscratch;
      `CSR_MEPC:     o_rdata = mepc;
      default:       o_rdata = '0;
    endcase
  end

  always_comb begin
    case (i_op)
      rv_pkg::CSR_WRITE: wval = i_wdata;
      rv_pkg::CSR_SET:   wval = o_rdata | i_wdata;
      rv_pkg::CSR_CLEAR: wval = o_rdata & ~i_wdata;
      default:           wval = o_rdata;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mstatus  <= '0;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
    end else if (i_en && (i_op != rv_pkg::CSR_NONE)) begin
      // unknown addresses fall through untouched
      case (i_addr)
        `CSR_MSTATUS:  mstatus  <= wval;
        `CSR_MTVEC:    mtvec    <= wval;
        `CSR_MSCRATCH: mscratch <= wval;
        `CSR_MEPC:     mepc     <= wval;
        default:       ;
      endcase
    end
  end

endmodule

//--- src/ex_unit.sv
/* execute unit
   ALU, issue decision, register writeback and downstream credit tracking */
`timescale 1ns/1ps
`include "rv_defs.svh"

module ex_unit (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_empty,
  input  rv_pkg::xlen_t    i_op1,
  input  rv_pkg::xlen_t    i_op2,
  input  rv_pkg::alu_op_e  i_alu_op,
  input  rv_pkg::reg_idx_t i_rd,
  input  logic             i_rd_wen,
  input  logic             i_illegal,
  input  logic             i_wb_credit,
  output logic             o_issue,
  output logic             o_rf_wen,
  output rv_pkg::xlen_t    o_rf_wdata,
  output logic             o_wb_valid,
  output rv_pkg::reg_idx_t o_wb_rd,
  output rv_pkg::xlen_t    o_wb_data,
  output logic             o_wb_illegal
);

  localparam int CW = $clog2(`WB_CREDITS + 1);

  logic [CW-1:0] credit_cnt;
  rv_pkg::xlen_t alu_res;

  always_comb begin
    case (i_alu_op)
      rv_pkg::ALU_ADD:  alu_res = i_op1 + i_op2;
      rv_pkg::ALU_SUB:  alu_res = i_op1 - i_op2;
      rv_pkg::ALU_XOR:  alu_res = i_op1 ^ i_op2;
      rv_pkg::ALU_OR:   alu_res = i_op1 | i_op2;
      rv_pkg::ALU_AND:  alu_res = i_op1 & i_op2;
      rv_pkg::ALU_SLL:  alu_res = i_op1 << i_op2[5:0];
      rv_pkg::ALU_SRL:  alu_res = i_op1 >> i_op2[5:0];
      default:          alu_res = i_op1;
    endcase
  end

  // one instruction per cycle while a writeback slot is free downstream
  assign o_issue    = !i_empty && (credit_cnt != '0);
  assign o_rf_wen   = o_issue && i_rd_wen && !i_illegal;
  assign o_rf_wdata = alu_res;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wb_valid <= 1'b0;
      credit_cnt <= CW'(`WB_CREDITS);
    end else begin
      o_wb_valid <= o_issue;
      case ({o_issue, i_wb_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_issue) begin
      o_wb_rd      <= i_illegal ? '0 : i_rd;
      o_wb_data    <= i_illegal ? '0 : alu_res;
      o_wb_illegal <= i_illegal;
    end
  end

  // sink must never return more credit than it was given
  a_credit_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    credit_cnt <= CW'(`WB_CREDITS))
    else $error("writeback credit count above limit");

endmodule

//--- src/id_core.sv
/* decode-and-execute core
   queue, decoder, register file, CSR file and execute unit */
`timescale 1ns/1ps

module id_core (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_inst_valid,
  input  rv_pkg::inst_word_u i_inst,
  input  rv_pkg::xlen_t      i_pc,
  output logic               o_inst_credit,
  input  logic               i_wb_credit,
  output logic               o_wb_valid,
  output rv_pkg::reg_idx_t   o_wb_rd,
  output rv_pkg::xlen_t      o_wb_data,
  output logic               o_wb_illegal
);

  logic               issue;
  logic               empty;
  rv_pkg::inst_word_u q_inst;
  rv_pkg::xlen_t      q_pc;
  rv_pkg::reg_idx_t   rs1;
  rv_pkg::reg_idx_t   rs2;
  rv_pkg::reg_idx_t   rd;
  logic               rd_wen;
  rv_pkg::xlen_t      rs1_data;
  rv_pkg::xlen_t      rs2_data;
  rv_pkg::xlen_t      op1;
  rv_pkg::xlen_t      op2;
  rv_pkg::alu_op_e    alu_op;
  logic               illegal;
  logic [11:0]        csr_addr;
  rv_pkg::csr_op_e    csr_op;
  rv_pkg::xlen_t      csr_wdata;
  rv_pkg::xlen_t      csr_rdata;
  logic               rf_wen;
  rv_pkg::xlen_t      rf_wdata;

  inst_queue inst_queue_inst (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_push   (i_inst_valid),
    .i_inst   (i_inst),
    .i_pc     (i_pc),
    .i_pop    (issue),
    .o_empty  (empty),
    .o_inst   (q_inst),
    .o_pc     (q_pc),
    .o_credit (o_inst_credit)
  );

  id_unit id_unit_inst (
    .i_ena       (issue),
    .i_inst      (q_inst),
    .i_pc        (q_pc),
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .i_csr_rdata (csr_rdata),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .o_rd        (rd),
    .o_rd_wen    (rd_wen),
    .o_op1       (op1),
    .o_op2       (op2),
    .o_alu_op    (alu_op),
    .o_illegal   (illegal),
    .o_csr_addr  (csr_addr),
    .o_csr_op    (csr_op),
    .o_csr_wdata (csr_wdata)
  );

  regfile regfile_inst (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_wen      (rf_wen),
    .i_rd       (rd),
    .i_wdata    (rf_wdata),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  csr_file csr_file_inst (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_en    (issue),
    .i_addr  (csr_addr),
    .i_op    (csr_op),
    .i_wdata (csr_wdata),
    .o_rdata (csr_rdata)
  );

  ex_unit ex_unit_inst (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_empty      (empty),
    .i_op1        (op1),
    .i_op2        (op2),
    .i_alu_op     (alu_op),
    .i_rd         (rd),
    .i_rd_wen     (rd_wen),
    .i_illegal    (illegal),
    .i_wb_credit  (i_wb_credit),
    .o_issue      (issue),
    .o_rf_wen     (rf_wen),
    .o_rf_wdata   (rf_wdata),
    .o_wb_valid   (o_wb_valid),
    .o_wb_rd      (o_wb_rd),
    .o_wb_data    (o_wb_data),
    .o_wb_illegal (o_wb_illegal)
  );

endmodule

//--- src/id_unit.sv
/* instruction decode unit
   splits the word into fields, picks operands, ALU op and CSR access */
`timescale 1ns/1ps
`include "rv_defs.svh"

module id_unit (
  input  logic               i_ena,
  input  rv_pkg::inst_word_u i_inst,
  input  rv_pkg::xlen_t      i_pc,
  input  rv_pkg::xlen_t      i_rs1_data,
  input  rv_pkg::xlen_t      i_rs2_data,
  input  rv_pkg::xlen_t      i_csr_rdata,
  output rv_pkg::reg_idx_t   o_rs1,
  output rv_pkg::reg_idx_t   o_rs2,
  output rv_pkg::reg_idx_t   o_rd,
  output logic               o_rd_wen,
  output rv_pkg::xlen_t      o_op1,
  output rv_pkg::xlen_t      o_op2,
  output rv_pkg::alu_op_e    o_alu_op,
  output logic               o_illegal,
  output logic [11:0]        o_csr_addr,
  output rv_pkg::csr_op_e    o_csr_op,
  output rv_pkg::xlen_t      o_csr_wdata
);

  logic [6:0]     opcode;
  logic [2:0]     funct3;
  rv_pkg::itype_e itype;
  rv_pkg::xlen_t  imm_i;
  rv_pkg::xlen_t  imm_u;
  rv_pkg::xlen_t  shamt;
  rv_pkg::xlen_t  zimm;
  logic           illegal;

  assign opcode = i_inst.r.opcode;
  assign funct3 = i_inst.r.funct3;
  assign imm_i  = {{52{i_inst.i.imm[11]}}, i_inst.i.imm};
  assign imm_u  = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  // RV64 shifts use a 6-bit shamt
  assign shamt  = {58'd0, i_inst.i.imm[5:0]};
  assign zimm   = {59'd0, i_inst.i.rs1};

  always_comb begin
    case (opcode)
      `OPCODE_LUI,
      `OPCODE_AUIPC:  itype = rv_pkg::ITYPE_U;
      `OPCODE_OPIMM,
      `OPCODE_SYSTEM: itype = rv_pkg::ITYPE_I;
      `OPCODE_OP:     itype = rv_pkg::ITYPE_R;
      default:        itype = rv_pkg::ITYPE_NONE;
    endcase
  end

  always_comb begin
    o_rs1       = '0;
    o_rs2       = '0;
    o_rd        = '0;
    o_op1       = '0;
    o_op2       = '0;
    o_alu_op    = rv_pkg::ALU_ADD;
    o_csr_addr  = '0;
    o_csr_op    = rv_pkg::CSR_NONE;
    o_csr_wdata = '0;
    illegal     = 1'b0;
    if (i_ena) begin
      o_rd = i_inst.r.rd;
      case (itype)
        rv_pkg::ITYPE_R: begin
          o_rs1 = i_inst.r.rs1;
          o_rs2 = i_inst.r.rs2;
          o_op1 = i_rs1_data;
          o_op2 = i_rs2_data;
          case ({i_inst.r.funct7, funct3})
            {7'h00, `FUNCT3_ADD}: o_alu_op = rv_pkg::ALU_ADD;
            {7'h20, `FUNCT3_ADD}: o_alu_op = rv_pkg::ALU_SUB;
            {7'h00, `FUNCT3_XOR}: o_alu_op = rv_pkg::ALU_XOR;
            {7'h00, `FUNCT3_OR}:  o_alu_op = rv_pkg::ALU_OR;
            {7'h00, `FUNCT3_AND}: o_alu_op = rv_pkg::ALU_AND;
            default:              illegal  = 1'b1;
          endcase
        end
        rv_pkg::ITYPE_I: begin
          if (opcode == `OPCODE_SYSTEM) begin
            // old CSR value passes through to rd
            o_op1      = i_csr_rdata;
            o_alu_op   = rv_pkg::ALU_PASS;
            o_csr_addr = i_inst.i.imm;
            o_csr_wdata = funct3[2] ? zimm : i_rs1_data;
            if (!funct3[2]) begin
              o_rs1 = i_inst.i.rs1;
            end
            case (funct3)
              `FUNCT3_CSRRW, `FUNCT3_CSRRWI: o_csr_op = rv_pkg::CSR_WRITE;
              `FUNCT3_CSRRS, `FUNCT3_CSRRSI: o_csr_op = rv_pkg::CSR_SET;
              `FUNCT3_CSRRC, `FUNCT3_CSRRCI: o_csr_op = rv_pkg::CSR_CLEAR;
              default:                       illegal  = 1'b1;
            endcase
          end else begin
            o_rs1 = i_inst.i.rs1;
            o_op1 = i_rs1_data;
            o_op2 = imm_i;
            case (funct3)
              `FUNCT3_ADD: o_alu_op = rv_pkg::ALU_ADD;
              `FUNCT3_XOR: o_alu_op = rv_pkg::ALU_XOR;
              `FUNCT3_OR:  o_alu_op = rv_pkg::ALU_OR;
              `FUNCT3_AND: o_alu_op = rv_pkg::ALU_AND;
              `FUNCT3_SLL: begin
                o_alu_op = rv_pkg::ALU_SLL;
                o_op2    = shamt;
                illegal  = (i_inst.i.imm[11:6] != 6'd0);
              end
              `FUNCT3_SRL: begin
                // srai has imm[10] set and is not supported
                o_alu_op = rv_pkg::ALU_SRL;
                o_op2    = shamt;
                illegal  = (i_inst.i.imm[11:6] != 6'd0);
              end
              default: illegal = 1'b1;
            endcase
          end
        end
        rv_pkg::ITYPE_U: begin
          if (opcode == `OPCODE_LUI) begin
            o_op1    = imm_u;
            o_alu_op = rv_pkg::ALU_PASS;
          end else begin
            o_op1    = i_pc;
            o_op2    = imm_u;
            o_alu_op = rv_pkg::ALU_ADD;
          end
        end
        default: illegal = 1'b1;
      endcase
    end
  end

  assign o_illegal = illegal;
  assign o_rd_wen  = i_ena && !illegal;

endmodule

//--- src/inst_queue.sv
/* instruction queue
   circular FIFO of instructions and PCs, returns one upstream credit per pop */
`timescale 1ns/1ps
`include "rv_defs.svh"

module inst_queue (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_push,
  input  rv_pkg::inst_word_u i_inst,
  input  rv_pkg::xlen_t      i_pc,
  input  logic               i_pop,
  output logic               o_empty,
  output rv_pkg::inst_word_u o_inst,
  output rv_pkg::xlen_t      o_pc,
  output logic               o_credit
);

  localparam int PW = $clog2(`IN_DEPTH);
  localparam int CW = $clog2(`IN_DEPTH + 1);

  rv_pkg::inst_word_u inst_mem [`IN_DEPTH];
  rv_pkg::xlen_t      pc_mem   [`IN_DEPTH];
  logic [PW-1:0]      wr_ptr;
  logic [PW-1:0]      rd_ptr;
  logic [CW-1:0]      count;
  logic               full;

  assign full    = (count == CW'(`IN_DEPTH));
  assign o_empty = (count == '0);
  assign o_inst  = inst_mem[rd_ptr];
  assign o_pc    = pc_mem[rd_ptr];

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      inst_mem[wr_ptr] <= i_inst;
      pc_mem[wr_ptr]   <= i_pc;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      o_credit <= 1'b0;
    end else begin
      o_credit <= i_pop;
      if (i_push) begin
        wr_ptr <= (wr_ptr == PW'(`IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= (rd_ptr == PW'(`IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({i_push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // a push into a full queue means the source spent a credit it did not hold
  a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_push |-> !full)
    else $error("instruction pushed into full queue");

endmodule

//--- src/regfile.sv
/* integer register file
   32 x 64-bit, two combinational reads, one write, x0 reads zero */
`timescale 1ns/1ps

module regfile (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  rv_pkg::reg_idx_t i_rs1,
  input  rv_pkg::reg_idx_t i_rs2,
  input  logic             i_wen,
  input  rv_pkg::reg_idx_t i_rd,
  input  rv_pkg::xlen_t    i_wdata,
  output rv_pkg::xlen_t    o_rs1_data,
  output rv_pkg::xlen_t    o_rs2_data
);

  rv_pkg::xlen_t regs [32];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_rd != '0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

  // x0 hardwired
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

//--- src/rv_defs.svh
/* RV64 slice constants
   major opcodes, function codes, machine CSR addresses and credit depths */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// major opcodes
`define OPCODE_LUI     7'b0110111
`define OPCODE_AUIPC   7'b0010111
`define OPCODE_OPIMM   7'b0010011
`define OPCODE_OP      7'b0110011
`define OPCODE_SYSTEM  7'b1110011

// funct3 for OP and OP-IMM
`define FUNCT3_ADD     3'b000
`define FUNCT3_SLL     3'b001
`define FUNCT3_XOR     3'b100
`define FUNCT3_SRL     3'b101
`define FUNCT3_OR      3'b110
`define FUNCT3_AND     3'b111

// funct3 for SYSTEM
`define FUNCT3_CSRRW   3'b001
`define FUNCT3_CSRRS   3'b010
`define FUNCT3_CSRRC   3'b011
`define FUNCT3_CSRRWI  3'b101
`define FUNCT3_CSRRSI  3'b110
`define FUNCT3_CSRRCI  3'b111

`define CSR_MSTATUS    12'h300
`define CSR_MTVEC      12'h305
`define CSR_MSCRATCH   12'h340
`define CSR_MEPC       12'h341

// queue slots double as the initial upstream credit
`define IN_DEPTH       4
`define WB_CREDITS     2

`endif

//--- src/rv_pkg.sv
/* RV64 slice shared types
   data words, decode enums and the instruction word union */
package rv_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [2:0] {ITYPE_NONE, ITYPE_R, ITYPE_I, ITYPE_U} itype_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_PASS
  } alu_op_e;

  typedef enum logic [1:0] {CSR_NONE, CSR_WRITE, CSR_SET, CSR_CLEAR} csr_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } inst_r_t;

  // imm is also the CSR address, rs1 the CSR zimm
  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } inst_i_t;

  typedef union packed {
    inst_r_t r;
    inst_i_t i;
  } inst_word_u;

endpackage

//--- tests/tb_id_core.sv
/* testbench for the decode-and-execute core
   table-driven program with credit models on both handshakes */
`timescale 1ns/1ps
`include "rv_defs.svh"

module tb_id_core;

  localparam int MAX_ENTRIES = 48;
  // sink withholds writeback credits this many cycles after reset
  localparam int HOLD_CYCLES = 12;

  logic               clk;
  logic               rst_n;
  logic               inst_valid;
  rv_pkg::inst_word_u inst;
  rv_pkg::xlen_t      pc;
  logic               inst_credit;
  logic               wb_credit;
  logic               wb_valid;
  rv_pkg::reg_idx_t   wb_rd;
  rv_pkg::xlen_t      wb_data;
  logic               wb_illegal;

  logic [31:0]      tab_inst [MAX_ENTRIES];
  rv_pkg::xlen_t    tab_pc   [MAX_ENTRIES];
  rv_pkg::reg_idx_t exp_rd   [MAX_ENTRIES];
  rv_pkg::xlen_t    exp_data [MAX_ENTRIES];
  logic             exp_ill  [MAX_ENTRIES];
  int               n_entries;
  rv_pkg::xlen_t    next_pc;

  // table indices in flight, oldest first
  int sb_q [$];
  int seed;
  int up_credits;
  int sent;
  int wb_count;
  int owed;
  int gap;
  int cycle_no;
  int extra;
  int cycles;
  int limit;

  id_core id_core_inst (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_inst_valid  (inst_valid),
    .i_inst        (inst),
    .i_pc          (pc),
    .o_inst_credit (inst_credit),
    .i_wb_credit   (wb_credit),
    .o_wb_valid    (wb_valid),
    .o_wb_rd       (wb_rd),
    .o_wb_data     (wb_data),
    .o_wb_illegal  (wb_illegal)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `OPCODE_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  task automatic add_entry(input logic [31:0] word, input rv_pkg::reg_idx_t rd,
                           input rv_pkg::xlen_t data, input logic ill);
    tab_inst[n_entries] = word;
    tab_pc[n_entries]   = next_pc;
    exp_rd[n_entries]   = rd;
    exp_data[n_entries] = data;
    exp_ill[n_entries]  = ill;
    n_entries++;
    next_pc = next_pc + 64'd4;
  endtask

  task automatic build_table();
    n_entries = 0;
    next_pc   = 64'h1000;
    // ALU chain through x1..x12
    add_entry(enc_i(12'd5, 5'd0, `FUNCT3_ADD, 5'd1, `OPCODE_OPIMM), 5'd1, 64'd5, 1'b0);
    add_entry(enc_i(12'hffd, 5'd1, `FUNCT3_ADD, 5'd2, `OPCODE_OPIMM), 5'd2, 64'd2, 1'b0);
    add_entry(enc_i(12'h0ff, 5'd2, `FUNCT3_XOR, 5'd3, `OPCODE_OPIMM), 5'd3, 64'hfd, 1'b0);
    add_entry(enc_i(12'h700, 5'd3, `FUNCT3_OR, 5'd4, `OPCODE_OPIMM), 5'd4, 64'h7fd, 1'b0);
    add_entry(enc_i(12'h0f0, 5'd4, `FUNCT3_AND, 5'd5, `OPCODE_OPIMM), 5'd5, 64'hf0, 1'b0);
    add_entry(enc_i(12'd36, 5'd5, `FUNCT3_SLL, 5'd6, `OPCODE_OPIMM), 5'd6,
              64'h0000_0f00_0000_0000, 1'b0);
    add_entry(enc_i(12'd8, 5'd6, `FUNCT3_SRL, 5'd7, `OPCODE_OPIMM), 5'd7,
              64'h0000_000f_0000_0000, 1'b0);
    add_entry(enc_r(7'h00, 5'd1, 5'd7, `FUNCT3_ADD, 5'd8), 5'd8, 64'h0000_000f_0000_0005, 1'b0);
    add_entry(enc_r(7'h20, 5'd8, 5'd2, `FUNCT3_ADD, 5'd9), 5'd9, 64'hffff_fff0_ffff_fffd, 1'b0);
    add_entry(enc_r(7'h00, 5'd3, 5'd9, `FUNCT3_XOR, 5'd10), 5'd10,
              64'hffff_fff0_ffff_ff00, 1'b0);
    add_entry(enc_r(7'h00, 5'd1, 5'd10, `FUNCT3_OR, 5'd11), 5'd11,
              64'hffff_fff0_ffff_ff05, 1'b0);
    add_entry(enc_r(7'h00, 5'd4, 5'd11, `FUNCT3_AND, 5'd12), 5'd12, 64'h705, 1'b0);
    // upper immediates
    add_entry(enc_u(20'h80001, 5'd13, `OPCODE_LUI), 5'd13, 64'hffff_ffff_8000_1000, 1'b0);
    next_pc = 64'h1034;
    add_entry(enc_u(20'h12345, 5'd14, `OPCODE_AUIPC), 5'd14, 64'h1234_6034, 1'b0);
    next_pc = 64'h2000;
    add_entry(enc_u(20'hfffff, 5'd15, `OPCODE_AUIPC), 5'd15, 64'h1000, 1'b0);
    // mscratch 0 -> 5 -> 7 -> 2
    add_entry(enc_i(`CSR_MSCRATCH, 5'd1, `FUNCT3_CSRRW, 5'd16, `OPCODE_SYSTEM),
              5'd16, 64'd0, 1'b0);
    add_entry(enc_i(`CSR_MSCRATCH, 5'd2, `FUNCT3_CSRRS, 5'd17, `OPCODE_SYSTEM),
              5'd17, 64'd5, 1'b0);
    add_entry(enc_i(`CSR_MSCRATCH, 5'd1, `FUNCT3_CSRRC, 5'd18, `OPCODE_SYSTEM),
              5'd18, 64'd7, 1'b0);
    // mtvec 0 -> 0x1f -> 0x1c -> 0x1e
    add_entry(enc_i(`CSR_MTVEC, 5'd31, `FUNCT3_CSRRWI, 5'd19, `OPCODE_SYSTEM),
              5'd19, 64'd0, 1'b0);
    add_entry(enc_i(`CSR_MTVEC, 5'd3, `FUNCT3_CSRRCI, 5'd20, `OPCODE_SYSTEM),
              5'd20, 64'h1f, 1'b0);
    add_entry(enc_i(`CSR_MTVEC, 5'd2, `FUNCT3_CSRRSI, 5'd21, `OPCODE_SYSTEM),
              5'd21, 64'h1c, 1'b0);
    add_entry(enc_i(`CSR_MTVEC, 5'd0, `FUNCT3_CSRRS, 5'd22, `OPCODE_SYSTEM),
              5'd22, 64'h1e, 1'b0);
    add_entry(enc_i(`CSR_MSCRATCH, 5'd0, `FUNCT3_CSRRS, 5'd23, `OPCODE_SYSTEM),
              5'd23, 64'd2, 1'b0);
    add_entry(enc_i(`CSR_MEPC, 5'd9, `FUNCT3_CSRRW, 5'd24, `OPCODE_SYSTEM),
              5'd24, 64'd0, 1'b0);
    add_entry(enc_i(`CSR_MEPC, 5'd0, `FUNCT3_CSRRS, 5'd25, `OPCODE_SYSTEM),
              5'd25, 64'hffff_fff0_ffff_fffd, 1'b0);
    add_entry(enc_i(`CSR_MSTATUS, 5'd8, `FUNCT3_CSRRSI, 5'd30, `OPCODE_SYSTEM),
              5'd30, 64'd0, 1'b0);
    add_entry(enc_i(`CSR_MSTATUS, 5'd0, `FUNCT3_CSRRS, 5'd31, `OPCODE_SYSTEM),
              5'd31, 64'd8, 1'b0);
    // unknown CSR address reads zero, even after a write
    add_entry(enc_i(12'h7c0, 5'd1, `FUNCT3_CSRRW, 5'd26, `OPCODE_SYSTEM), 5'd26, 64'd0, 1'b0);
    add_entry(enc_i(12'h7c0, 5'd0, `FUNCT3_CSRRS, 5'd27, `OPCODE_SYSTEM), 5'd27, 64'd0, 1'b0);
    // x0 write is dropped, later read sees zero
    add_entry(enc_i(12'd123, 5'd1, `FUNCT3_ADD, 5'd0, `OPCODE_OPIMM), 5'd0, 64'd128, 1'b0);
    add_entry(enc_r(7'h00, 5'd1, 5'd0, `FUNCT3_ADD, 5'd28), 5'd28, 64'd5, 1'b0);
    // a load into x1 is illegal here and must leave x1 alone
    add_entry(enc_i(12'd0, 5'd1, 3'b011, 5'd1, 7'b0000011), 5'd0, 64'd0, 1'b1);
    add_entry(enc_i(12'd1, 5'd1, `FUNCT3_ADD, 5'd29, `OPCODE_OPIMM), 5'd29, 64'd6, 1'b0);
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0d ns: %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1, "wrong value seen");
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_wb(input rv_pkg::reg_idx_t rd, input rv_pkg::xlen_t data,
                          input logic ill);
    int idx;
    if (sb_q.size() == 0) begin
      abort_run("A writeback came out with no instruction outstanding.");
    end else begin
      idx = sb_q.pop_front();
      if (rd !== exp_rd[idx] || data !== exp_data[idx] || ill !== exp_ill[idx]) begin
        report_error($sformatf("entry %0d got rd %0d data %h illegal %b, want %0d %h %b",
                               idx, rd, data, ill, exp_rd[idx], exp_data[idx], exp_ill[idx]));
      end
    end
  endtask

  task automatic check_credits(input int credits);
    if (credits < 0 || credits > `IN_DEPTH) begin
      report_error($sformatf("upstream credit count %0d outside 0..%0d", credits, `IN_DEPTH));
    end
  endtask

  // run limit scales with the table
  initial begin
    cycles = 0;
    @(posedge rst_n);
    limit = n_entries * 20 + 100;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("TESTS FAILED");
    $fatal(1, "Timed out: the program did not complete within %0d cycles.", limit);
  end

  initial begin
    seed       = 32'hed0eb38d;
    rst_n      = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    pc         = '0;
    wb_credit  = 1'b0;
    up_credits = `IN_DEPTH;
    sent       = 0;
    wb_count   = 0;
    owed       = 0;
    gap        = 0;
    cycle_no   = 0;
    extra      = 0;
    build_table();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    while (wb_count < n_entries) begin
      @(negedge clk);
      cycle_no++;
      if (inst_credit) begin
        up_credits++;
      end
      check_credits(up_credits);
      if (wb_valid) begin
        check_wb(wb_rd, wb_data, wb_illegal);
        wb_count++;
        owed++;
        if (cycle_no <= HOLD_CYCLES && wb_count > `WB_CREDITS) begin
          report_error("writeback issued without downstream credit");
        end
      end
      if (cycle_no == HOLD_CYCLES) begin
        if (wb_count != `WB_CREDITS) begin
          report_error($sformatf("%0d writebacks while credits withheld, want %0d",
                                 wb_count, `WB_CREDITS));
        end
        if (up_credits != 0) begin
          report_error($sformatf("source holds %0d credits, queue should be full",
                                 up_credits));
        end
      end

      inst_valid = 1'b0;
      if (up_credits > 0 && sent < n_entries) begin
        inst_valid = 1'b1;
        inst       = tab_inst[sent];
        pc         = tab_pc[sent];
        sb_q.push_back(sent);
        sent++;
        up_credits--;
      end

      // sink returns credits after random gaps
      wb_credit = 1'b0;
      if (cycle_no > HOLD_CYCLES && owed > 0) begin
        if (gap == 0) begin
          wb_credit = 1'b1;
          owed--;
          gap = $random(seed) & 3;
        end else begin
          gap--;
        end
      end
    end

    // nothing may follow the last entry
    repeat (5) begin
      @(negedge clk);
      wb_credit = 1'b0;
      if (wb_valid) begin
        extra++;
      end
    end

    if (extra == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("%0d extra writebacks came out after the last entry.", extra);
      $display("TESTS FAILED");
      $fatal(1, "run ended with mismatched writebacks");
    end
  end

endmodule
